// ==== Bender.yml ====
package:
  name: spi_master

sources:
  - include_dirs:
      - common
    files:
      - common/spi_cfg_pkg.sv
      - common/spi_engine_pkg.sv
      - host_buffer/spi_host_buffer.sv
      - shift_engine/spi_bit_clock.sv
      - shift_engine/spi_shift_engine.sv
      - src/spi_master.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - dv/tb_spi_master.sv

// ==== common/spi_cfg_pkg.sv ====
`include "spi_master_defines.svh"

// Types that the host sees on the SPI master ports.
package spi_cfg_pkg;

    // One data word, sent or received in a single frame.
    typedef logic [`SPI_WORD_LEN-1:0] spi_word_t;

    // SPI mode as two bits, polarity above phase, so that the
    // usual mode numbers 0 to 3 map straight onto the packed value.
    typedef struct packed {
        logic cpol;  // Idle level of sck. 1 means sck idles high.
        logic cpha;  // 1 means data is sampled on the second edge.
    } spi_mode_t;

    // Prescaler select. The sck half period is 2 ** (select + 1) wr cycles,
    // so the values 0 to 7 give half periods from 2 up to 256 cycles.
    typedef logic [`SPI_PRESC_SEL_W-1:0] spi_presc_t;

endpackage

// ==== common/spi_engine_pkg.sv ====
`include "spi_master_defines.svh"

// Types used only inside the shift engine.
package spi_engine_pkg;

    // Position inside a frame. The phase bit is the low bit of the count,
    // so two steps make one bit and one sck period.
    typedef struct packed {
        logic [`SPI_BIT_NUM_W-1:0] bit_num;  // Bit being transferred.
        logic                      phase;    // First or second half of the bit.
    } spi_step_pos_t;

    // The step counter is incremented as a plain count, but
    // the sampling and frame-end decisions read it as a bit position.
    typedef union packed {
        logic [`SPI_STEP_W-1:0] raw;  // Half periods since ss fell.
        spi_step_pos_t          pos;  // Same bits split into bit and phase.
    } spi_step_t;

    // Frame state. Busy covers the 16 half periods of one frame.
    typedef enum logic {
        state_idle,
        state_busy
    } spi_state_t;

endpackage

// ==== common/spi_master_defines.svh ====
`ifndef SPI_MASTER_DEFINES_SVH
`define SPI_MASTER_DEFINES_SVH

//////////////////////////////////////////////////
// Frame geometry.
//////////////////////////////////////////////////

// Number of data bits carried by one SPI frame.
`define SPI_WORD_LEN 8

// Width of the bit-number field of the step counter.
// It must hold the index of the last bit of a frame.
`define SPI_BIT_NUM_W 4

// The step counter is the bit number with one phase bit below it.
`define SPI_STEP_W (`SPI_BIT_NUM_W + 1)

//////////////////////////////////////////////////
// Bit clock prescaler.
//////////////////////////////////////////////////

// Width of the prescaler select that the host writes with each word.
`define SPI_PRESC_SEL_W 3

// Width of the half-period counter. It holds the longest limit, 255.
`define SPI_PRESC_CNT_W 8

`endif

// ==== dv/spi_master_vectors.txt ====
# kind: 0 exchange, 1 send error, 2 back-to-back (second word is tx inverted)
# kind tx reply mode lsb_first prescaler exp_rx exp_slave, all hex
0 a5 3c 0 0 0 3c a5
0 a5 3c 0 1 1 3c a5
0 96 e1 1 0 2 e1 96
0 96 e1 1 1 0 e1 96
0 5a 81 2 0 1 81 5a
0 5a 81 2 1 3 81 5a
0 c3 7e 3 0 0 7e c3
0 c3 7e 3 1 4 7e c3
0 01 80 0 0 5 80 01
0 80 01 3 1 6 01 80
0 ff 00 1 0 7 00 ff
0 00 ff 2 1 0 ff 00
1 6d b2 0 0 1 b2 6d
1 39 4e 3 1 0 4e 39
2 4b d2 1 0 1 d2 b4
2 e7 18 2 1 0 18 18

// ==== dv/tb_spi_master.sv ====
`include "spi_master_defines.svh"

module tb_spi_master;
    import spi_cfg_pkg::*;

    localparam int MAX_VEC  = 32;
    localparam int TEST_LIM = 4300;  // Cycles per test, enough for one frame at select 7.

    logic       wr = 1'b0;
    logic       rst;
    logic       send;
    spi_word_t  data_in;
    spi_presc_t prescaler;
    spi_mode_t  mode;
    logic       lsb_first;
    logic       read;
    spi_word_t  data_out;
    logic       buff_empty;
    logic       send_err;
    logic       res_send_err;
    logic       char_received;
    logic       sck;
    logic       mosi;
    logic       miso;
    logic       ss;

    // One entry per line of the vector file.
    logic [7:0] vec_kind  [0:MAX_VEC-1];
    spi_word_t  vec_tx    [0:MAX_VEC-1];
    spi_word_t  vec_reply [0:MAX_VEC-1];
    logic [1:0] vec_mode  [0:MAX_VEC-1];
    logic       vec_lsb   [0:MAX_VEC-1];
    int         vec_presc [0:MAX_VEC-1];
    spi_word_t  vec_rx    [0:MAX_VEC-1];
    spi_word_t  vec_slave [0:MAX_VEC-1];
    int         num_vec;

    // Settings of the running test. The slave model reads them too.
    logic [1:0] cur_mode;     // Polarity above phase.
    logic       cur_lsb;
    int         cur_presc;
    spi_word_t  slave_reply;

    // Slave model state.
    spi_word_t  cap_word;
    spi_word_t  captured_q [$];  // Words the slave saw, in order.
    logic       prev_ss;
    logic       prev_sck;
    logic       prev_mosi;
    logic       idle_cpol;       // Polarity of the last frame.
    logic       leading;
    logic       sample_edge;
    int         edge_cnt;
    int         bit_idx;
    int         hp_cnt = 0;      // Cycles since the last sck edge.
    int         ss_rises = 0;

    int errors       = 0;
    int tests_failed = 0;
    int errs_before;
    int cycles       = 0;
    int cycle_limit  = 1000;
    int seed;
    bit load_ok;

    spi_master i_spi_master (
        .wr            (wr),
        .rst           (rst),
        .send          (send),
        .data_in       (data_in),
        .prescaler     (prescaler),
        .mode          (mode),
        .lsb_first     (lsb_first),
        .read          (read),
        .data_out      (data_out),
        .buff_empty    (buff_empty),
        .send_err      (send_err),
        .res_send_err  (res_send_err),
        .char_received (char_received),
        .sck           (sck),
        .mosi          (mosi),
        .miso          (miso),
        .ss            (ss)
    );

    always #10 wr = ~wr;  // Period of 20.

    // Watchdog over the whole run.
    always @(posedge wr) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("Timeout: the run did not finish within %0d clock cycles.", cycle_limit);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Helpers.
    //////////////////////////////////////////////////

    task automatic report_err(input string msg);
        $display("ERR @%0t: %s", $time, msg);
        errors = errors + 1;
    endtask

    // Moves to 2 time units after the next rising edge, where inputs change.
    task automatic step_cycle();
        @(posedge wr);
        #2;
    endtask

    function automatic logic reply_bit(input int idx);
        return cur_lsb ? slave_reply[idx] : slave_reply[`SPI_WORD_LEN-1-idx];
    endfunction

    task automatic send_word(input spi_word_t w);
        data_in   = w;
        prescaler = cur_presc[2:0];
        mode      = cur_mode;
        lsb_first = cur_lsb;
        send      = 1'b1;
        step_cycle();
        send      = 1'b0;
    endtask

    // The watchdog covers a flag that never rises.
    task automatic receive_word(input spi_word_t expected);
        while (!char_received) step_cycle();
        if (data_out !== expected) begin
            report_err($sformatf("data_out is %h, expected %h", data_out, expected));
        end
    endtask

    task automatic pulse_read();
        read = 1'b1;
        step_cycle();
        read = 1'b0;
        if (char_received) report_err("char_received still high after read");
    endtask

    task automatic check_captured(input int n, input spi_word_t expected);
        if (captured_q.size() != n) begin
            report_err($sformatf("slave saw %0d frames, expected %0d", captured_q.size(), n));
        end else if (captured_q[n-1] !== expected) begin
            report_err($sformatf("slave captured %h, expected %h", captured_q[n-1], expected));
        end
    endtask

    //////////////////////////////////////////////////
    // SPI slave model.
    //////////////////////////////////////////////////

    // Runs just after each rising edge, when the pins have settled. An edge is a
    // change of sck while ss was low, so the final edge is seen even when ss rises
    // with it. mosi is taken from before the edge, as a real slave would see it.
    always @(posedge wr) begin
        #2;
        if (rst) begin
            prev_ss   = 1'b1;
            prev_sck  = 1'b0;
            prev_mosi = 1'b1;
            idle_cpol = 1'b0;  // Mode 0 out of reset.
            edge_cnt  = 0;
        end else begin
            hp_cnt = hp_cnt + 1;
            if (!prev_ss && sck !== prev_sck) begin
                leading     = (prev_sck == cur_mode[1]);  // Moving away from idle.
                sample_edge = leading ^ cur_mode[0];
                bit_idx     = edge_cnt / 2;
                // The first edge of a frame has no earlier edge to measure from.
                if (edge_cnt > 0 && hp_cnt != (2 << cur_presc)) begin
                    report_err($sformatf("sck half period is %0d cycles, expected %0d",
                                         hp_cnt, 2 << cur_presc));
                end
                hp_cnt = 0;
                if (sample_edge) begin
                    cap_word[cur_lsb ? bit_idx : `SPI_WORD_LEN-1-bit_idx] = prev_mosi;
                end else if (cur_mode[0]) begin
                    miso = reply_bit(bit_idx);  // Phase 1 drives on the leading edge.
                end else if (bit_idx < `SPI_WORD_LEN-1) begin
                    miso = reply_bit(bit_idx + 1);
                end
                edge_cnt = edge_cnt + 1;
                if (edge_cnt == 2 * `SPI_WORD_LEN) begin
                    captured_q.push_back(cap_word);
                    edge_cnt = 0;
                    miso     = reply_bit(0);  // Ready for a back-to-back frame.
                end
            end else if (prev_ss && !ss) begin
                edge_cnt  = 0;
                hp_cnt    = 0;
                idle_cpol = cur_mode[1];
                miso      = reply_bit(0);  // Phase 0 masters sample this on the first edge.
            end
            if (ss && !prev_ss) ss_rises = ss_rises + 1;
            if (ss && (sck !== idle_cpol || mosi !== 1'b1)) begin
                report_err($sformatf("idle pins sck %b mosi %b while ss is high", sck, mosi));
            end
            prev_ss   = ss;
            prev_sck  = sck;
            prev_mosi = mosi;
        end
    end

    //////////////////////////////////////////////////
    // Tests.
    //////////////////////////////////////////////////

    task automatic load_vectors(output bit ok);
        int fd;
        int n;
        logic [8*128-1:0] line;
        logic [31:0] fk, ft, fr, fm, fl, fp, fe, fs;
        num_vec = 0;
        fd = $fopen("dv/spi_master_vectors.txt", "r");
        if (fd != 0) begin
            while ($fgets(line, fd) > 0) begin
                // Comment and blank lines do not scan as eight fields.
                n = $sscanf(line, "%h %h %h %h %h %h %h %h", fk, ft, fr, fm, fl, fp, fe, fs);
                if (n == 8 && num_vec < MAX_VEC) begin
                    vec_kind[num_vec]  = fk[7:0];
                    vec_tx[num_vec]    = ft[7:0];
                    vec_reply[num_vec] = fr[7:0];
                    vec_mode[num_vec]  = fm[1:0];
                    vec_lsb[num_vec]   = fl[0];
                    vec_presc[num_vec] = fp;
                    vec_rx[num_vec]    = fe[7:0];
                    vec_slave[num_vec] = fs[7:0];
                    num_vec = num_vec + 1;
                end
            end
            $fclose(fd);
        end
        cycle_limit = num_vec * TEST_LIM + 1000;
        ok = (num_vec > 0);
    endtask

    task automatic run_exchange(input int t);
        send_word(vec_tx[t]);
        receive_word(vec_rx[t]);
        repeat (3) step_cycle();
        if (!char_received) report_err("char_received fell before read");
        pulse_read();
        while (!ss) step_cycle();
        check_captured(1, vec_slave[t]);
    endtask

    // The second word arrives while the first still waits in the buffer.
    task automatic run_send_error(input int t);
        send_word(vec_tx[t]);
        if (buff_empty) report_err("buff_empty still high after send");
        send_word(vec_tx[t] ^ 8'hff);
        if (!send_err) report_err("send_err not set by a send into a full buffer");
        receive_word(vec_rx[t]);
        pulse_read();
        while (!ss) step_cycle();
        repeat (4 << cur_presc) step_cycle();
        if (!ss) report_err("the dropped word started a frame");
        check_captured(1, vec_slave[t]);
        if (!send_err) report_err("send_err fell without res_send_err");
        res_send_err = 1'b1;
        step_cycle();
        res_send_err = 1'b0;
        if (send_err) report_err("send_err still high after res_send_err");
    endtask

    task automatic run_back_to_back(input int t);
        send_word(vec_tx[t]);
        while (!buff_empty) step_cycle();
        send_word(vec_tx[t] ^ 8'hff);  // Buffered while the first frame runs.
        receive_word(vec_rx[t]);
        pulse_read();
        receive_word(vec_rx[t]);
        pulse_read();
        while (!ss) step_cycle();
        check_captured(2, vec_slave[t]);
        if (captured_q.size() == 2 && captured_q[0] !== vec_tx[t]) begin
            report_err($sformatf("first frame carried %h, expected %h", captured_q[0], vec_tx[t]));
        end
        if (ss_rises != 1) report_err("ss rose between back-to-back frames");
    endtask

    initial begin
        rst          = 1'b1;
        send         = 1'b0;
        data_in      = '0;
        prescaler    = '0;
        mode         = '0;
        lsb_first    = 1'b0;
        read         = 1'b0;
        res_send_err = 1'b0;
        miso         = 1'b1;
        seed = $urandom(32'hae305528);
        load_vectors(load_ok);
        if (!load_ok) begin
            $display("Could not read any test from dv/spi_master_vectors.txt.");
            $display("Simulation finished: FAIL");
            $finish;
        end else begin
            repeat (16) @(posedge wr);
            #2;
            rst = 1'b0;
            for (int t = 0; t < num_vec; t++) begin
                errs_before = errors;
                repeat ($urandom % 6) step_cycle();  // Idle gap between tests.
                cur_mode    = vec_mode[t];
                cur_lsb     = vec_lsb[t];
                cur_presc   = vec_presc[t];
                slave_reply = vec_reply[t];
                captured_q.delete();
                ss_rises = 0;
                case (vec_kind[t])
                    8'd0: run_exchange(t);
                    8'd1: run_send_error(t);
                    8'd2: run_back_to_back(t);
                    default: report_err($sformatf("unknown test kind %0d", vec_kind[t]));
                endcase
                if (errors == errs_before) begin
                    $display("test %0d kind %0d mode %0d: ok", t, vec_kind[t], cur_mode);
                end else begin
                    tests_failed = tests_failed + 1;
                    $display("test %0d kind %0d mode %0d: failed", t, vec_kind[t], cur_mode);
                end
            end
            $display("tests run %0d, failed %0d, errors %0d", num_vec, tests_failed, errors);
            if (errors == 0 && tests_failed == 0) begin
                $display("Simulation finished: PASS");
            end else begin
                $display("Simulation finished: FAIL");
            end
            $finish;
        end
    end

endmodule

// ==== host_buffer/spi_host_buffer.sv ====
module spi_host_buffer (
    input  logic                    wr,
    input  logic                    rst,
    input  logic                    send,
    input  spi_cfg_pkg::spi_word_t  data_in,
    input  spi_cfg_pkg::spi_presc_t prescaler,
    input  spi_cfg_pkg::spi_mode_t  mode,
    input  logic                    lsb_first,
    input  logic                    res_send_err,
    output logic                    send_err,
    output logic                    buff_empty,
    output logic                    tx_full,
    output spi_cfg_pkg::spi_word_t  tx_data,
    output spi_cfg_pkg::spi_presc_t tx_prescaler,
    output spi_cfg_pkg::spi_mode_t  tx_mode,
    output logic                    tx_lsb_first,
    input  logic                    take,
    input  logic                    rx_done,
    input  spi_cfg_pkg::spi_word_t  rx_data,
    input  logic                    read,
    output spi_cfg_pkg::spi_word_t  data_out,
    output logic                    char_received
);

    logic accept;  // A send that finds the buffer empty.

    assign accept     = send & ~tx_full;
    assign buff_empty = ~tx_full;  // Host may send while this is high.

    //////////////////////////////////////////////////
    // Transmit side.
    //////////////////////////////////////////////////

    // The full flag is set by an accepted send and cleared when the engine
    // takes the word. Both cannot happen together, since take needs a full buffer.
    always_ff @(posedge wr or posedge rst) begin
        if (rst) begin
            tx_full <= 1'b0;
        end else if (accept) begin
            tx_full <= 1'b1;
        end else if (take) begin
            tx_full <= 1'b0;
        end
    end

    // The word travels with the configuration that was on the bus at send time.
    always_ff @(posedge wr) begin
        if (accept) begin
            tx_data      <= data_in;
            tx_prescaler <= prescaler;
            tx_mode      <= mode;
            tx_lsb_first <= lsb_first;
        end
    end

    // A send into a full buffer is dropped and only leaves this flag behind.
    always_ff @(posedge wr or posedge rst) begin
        if (rst) begin
            send_err <= 1'b0;
        end else if (res_send_err) begin
            send_err <= 1'b0;  // Clearing wins over a new error.
        end else if (send && tx_full) begin
            send_err <= 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // Receive side.
    //////////////////////////////////////////////////

    always_ff @(posedge wr) begin
        if (rx_done) begin
            data_out <= rx_data;  // Unread data is overwritten by the next frame.
        end
    end

    // A new frame keeps the flag up even if the host reads in the same cycle.
    always_ff @(posedge wr or posedge rst) begin
        if (rst) begin
            char_received <= 1'b0;
        end else if (rx_done) begin
            char_received <= 1'b1;
        end else if (read) begin
            char_received <= 1'b0;
        end
    end

    // The engine must only pull a word that the host has actually written.
    take_needs_word: assert property (@(posedge wr) disable iff (rst) take |-> tx_full)
        else $error("Shift engine took a word from an empty transmit buffer.");

endmodule

// ==== shift_engine/spi_bit_clock.sv ====
`include "spi_master_defines.svh"

module spi_bit_clock (
    input  logic                    wr,
    input  logic                    rst,
    input  logic                    run,
    input  spi_cfg_pkg::spi_presc_t frame_prescaler,
    output logic                    tick
);

    logic [`SPI_PRESC_CNT_W-1:0] cnt;         // wr cycles since the last tick.
    logic [`SPI_PRESC_CNT_W-1:0] half_limit;  // Last count value of a half period.

    //////////////////////////////////////////////////
    // Half-period limit.
    //////////////////////////////////////////////////

    // The limit is 2 ** (select + 1) - 1, a run of ones that is one bit
    // longer for each step of the select. Select 0 gives 1, select 7 gives 255.
    assign half_limit = {`SPI_PRESC_CNT_W{1'b1}} >> (`SPI_PRESC_CNT_W - 1 - frame_prescaler);

    //////////////////////////////////////////////////
    // Counter.
    //////////////////////////////////////////////////

    // The counter sits at zero between frames, so every frame starts
    // with a full half period before its first tick.
    always_ff @(posedge wr or posedge rst) begin
        if (rst) begin
            cnt <= '0;
        end else if (!run) begin
            cnt <= '0;
        end else if (cnt == half_limit) begin
            cnt <= '0;  // Restart for the next half period.
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // One cycle wide, once per half period.
    assign tick = run & (cnt == half_limit);

    // The select is latched once per frame. A change while the counter runs
    // could leave cnt above a lowered limit, and it would then wrap through 255.
    presc_held: assert property (@(posedge wr) disable iff (rst)
        run && $past(run) |-> $stable(frame_prescaler))
        else $error("Prescaler select changed while the bit clock was running.");

endmodule

// ==== shift_engine/spi_shift_engine.sv ====
`include "spi_master_defines.svh"

module spi_shift_engine (
    input  logic                    wr,
    input  logic                    rst,
    input  logic                    tx_full,
    input  spi_cfg_pkg::spi_word_t  tx_data,
    input  spi_cfg_pkg::spi_presc_t tx_prescaler,
    input  spi_cfg_pkg::spi_mode_t  tx_mode,
    input  logic                    tx_lsb_first,
    output logic                    take,
    output logic                    run,
    output spi_cfg_pkg::spi_presc_t frame_prescaler,
    input  logic                    tick,
    output logic                    rx_done,
    output spi_cfg_pkg::spi_word_t  rx_data,
    output logic                    sck,
    output logic                    mosi,
    input  logic                    miso,
    output logic                    ss
);
    import spi_cfg_pkg::*;
    import spi_engine_pkg::*;

    spi_state_t state;
    spi_step_t  step;           // Half periods into the current frame.
    spi_mode_t  cfg_mode;       // Mode of the frame in flight, or of the last one.
    logic       cfg_lsb_first;
    spi_word_t  shift_out;      // Bits still to be sent, head first.
    spi_word_t  shift_in;       // Bits received so far.
    logic       mosi_q;         // Registered data bit for the slave.
    logic       sample_phase;   // This half period ends with a sample.
    logic       last_step;      // Second half of the last bit.
    logic       out_head;       // Next bit to leave shift_out.

    //////////////////////////////////////////////////
    // Step decode.
    //////////////////////////////////////////////////

    // Sampling happens on the phase that matches cpha. With cpha 0 that is
    // the first edge of each bit, with cpha 1 the second.
    assign sample_phase = (step.pos.phase == cfg_mode.cpha);
    assign last_step    = step.pos.phase && (step.pos.bit_num == `SPI_WORD_LEN - 1);
    assign out_head     = cfg_lsb_first ? shift_out[0] : shift_out[`SPI_WORD_LEN-1];

    // A word is taken only from idle, which includes the single idle
    // cycle between back-to-back frames.
    assign take = (state == state_idle) && tx_full;
    assign run  = (state == state_busy);

    //////////////////////////////////////////////////
    // Frame control.
    //////////////////////////////////////////////////

    always_ff @(posedge wr or posedge rst) begin
        if (rst) begin
            state           <= state_idle;
            step            <= '0;
            ss              <= 1'b1;
            cfg_mode        <= '0;    // Mode 0, so sck idles low out of reset.
            cfg_lsb_first   <= 1'b0;
            frame_prescaler <= '0;
            mosi_q          <= 1'b1;
            rx_done         <= 1'b0;
        end else begin
            rx_done <= 1'b0;
            if (take) begin
                // Latch the whole configuration so the host can change it mid-frame.
                state           <= state_busy;
                step            <= '0;
                ss              <= 1'b0;
                cfg_mode        <= tx_mode;
                cfg_lsb_first   <= tx_lsb_first;
                frame_prescaler <= tx_prescaler;
                // First bit goes out with ss. Phase 0 slaves sample it on the first edge.
                mosi_q <= tx_lsb_first ? tx_data[0] : tx_data[`SPI_WORD_LEN-1];
            end else if (run && tick) begin
                step.raw <= step.raw + 1'b1;
                if (!sample_phase && !last_step) begin
                    mosi_q <= out_head;  // Drive on the edge away from the sample.
                end
                if (last_step) begin
                    step    <= '0;        // Phase 0 again, so sck returns to idle.
                    state   <= state_idle;
                    ss      <= ~tx_full;  // Stay selected if another word waits.
                    rx_done <= 1'b1;      // shift_in holds the full word next cycle.
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Shift registers.
    //////////////////////////////////////////////////

    // Both registers move on the sample phase. The outgoing side is refilled
    // with ones, which never reach the pin before the next word is loaded.
    always_ff @(posedge wr) begin
        if (take) begin
            shift_out <= tx_data;
        end else if (run && tick && sample_phase) begin
            if (cfg_lsb_first) begin
                shift_out <= {1'b1, shift_out[`SPI_WORD_LEN-1:1]};
            end else begin
                shift_out <= {shift_out[`SPI_WORD_LEN-2:0], 1'b1};
            end
        end
    end

    always_ff @(posedge wr) begin
        if (run && tick && sample_phase) begin
            if (cfg_lsb_first) begin
                shift_in <= {miso, shift_in[`SPI_WORD_LEN-1:1]};  // First bit ends at bit 0.
            end else begin
                shift_in <= {shift_in[`SPI_WORD_LEN-2:0], miso};  // First bit ends at the MSB.
            end
        end
    end

    assign rx_data = shift_in;

    //////////////////////////////////////////////////
    // Pin drive.
    //////////////////////////////////////////////////

    // The step phase is the raw clock. Polarity inverts it for idle-high modes.
    assign sck  = step.pos.phase ^ cfg_mode.cpol;
    assign mosi = ss ? 1'b1 : mosi_q;  // Line parks high while no slave is selected.

    // A frame must always end on a full sck period, leaving the clock at idle.
    idle_sck_level: assert property (@(posedge wr) disable iff (rst)
        ss |-> (sck == cfg_mode.cpol))
        else $error("sck is off its idle level while ss is high.");

endmodule

// ==== spi_master.f ====
+incdir+common
common/spi_cfg_pkg.sv
common/spi_engine_pkg.sv
host_buffer/spi_host_buffer.sv
shift_engine/spi_bit_clock.sv
shift_engine/spi_shift_engine.sv
src/spi_master.sv
dv/tb_spi_master.sv

// ==== src/spi_master.sv ====
module spi_master (
    input  logic                    wr,
    input  logic                    rst,
    input  logic                    send,
    input  spi_cfg_pkg::spi_word_t  data_in,
    input  spi_cfg_pkg::spi_presc_t prescaler,
    input  spi_cfg_pkg::spi_mode_t  mode,
    input  logic                    lsb_first,
    input  logic                    read,
    output spi_cfg_pkg::spi_word_t  data_out,
    output logic                    buff_empty,
    output logic                    send_err,
    input  logic                    res_send_err,
    output logic                    char_received,
    output logic                    sck,
    output logic                    mosi,
    input  logic                    miso,
    output logic                    ss
);
    import spi_cfg_pkg::*;

    //////////////////////////////////////////////////
    // Host buffer to shift engine.
    //////////////////////////////////////////////////

    logic       tx_full;       // A word waits for the engine.
    spi_word_t  tx_data;
    spi_presc_t tx_prescaler;
    spi_mode_t  tx_mode;
    logic       tx_lsb_first;
    logic       take;          // The engine accepts the waiting word.
    logic       rx_done;       // A frame has finished.
    spi_word_t  rx_data;

    // Shift engine to bit clock.
    logic       run;
    spi_presc_t frame_prescaler;
    logic       tick;

    spi_host_buffer i_host_buffer (
        .wr            (wr),
        .rst           (rst),
        .send          (send),
        .data_in       (data_in),
        .prescaler     (prescaler),
        .mode          (mode),
        .lsb_first     (lsb_first),
        .res_send_err  (res_send_err),
        .send_err      (send_err),
        .buff_empty    (buff_empty),
        .tx_full       (tx_full),
        .tx_data       (tx_data),
        .tx_prescaler  (tx_prescaler),
        .tx_mode       (tx_mode),
        .tx_lsb_first  (tx_lsb_first),
        .take          (take),
        .rx_done       (rx_done),
        .rx_data       (rx_data),
        .read          (read),
        .data_out      (data_out),
        .char_received (char_received)
    );

    spi_bit_clock i_bit_clock (
        .wr              (wr),
        .rst             (rst),
        .run             (run),
        .frame_prescaler (frame_prescaler),
        .tick            (tick)
    );

    spi_shift_engine i_shift_engine (
        .wr              (wr),
        .rst             (rst),
        .tx_full         (tx_full),
        .tx_data         (tx_data),
        .tx_prescaler    (tx_prescaler),
        .tx_mode         (tx_mode),
        .tx_lsb_first    (tx_lsb_first),
        .take            (take),
        .run             (run),
        .frame_prescaler (frame_prescaler),
        .tick            (tick),
        .rx_done         (rx_done),
        .rx_data         (rx_data),
        .sck             (sck),
        .mosi            (mosi),
        .miso            (miso),
        .ss              (ss)
    );

endmodule
